/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // bank geometry
    localparam int word_bytes     = 4;
    localparam int line_words     = 4;
    localparam int num_lines      = 16;
    localparam int line_addr_bits = 12;
    localparam int set_bits       = $clog2(num_lines);
    localparam int tag_bits       = line_addr_bits - set_bits;

    // both queues share one depth
    localparam int fifo_depth = 4;

    typedef logic [word_bytes*8-1:0]            word_t;
    typedef word_t [line_words-1:0]             line_t;
    typedef logic [line_addr_bits-1:0]          line_addr_t;
    typedef logic [$clog2(line_words)-1:0]      wsel_t;
    typedef logic [word_bytes-1:0]              byteen_t;
    typedef logic [line_words*word_bytes-1:0]   line_byteen_t;
    typedef logic [3:0]                         core_tag_t;

    typedef struct packed {
        core_tag_t tag;
        word_t     data;
    } core_rsp_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } mem_req_t;

    // what a stage entry does
    typedef enum logic [2:0] {
        none,
        init,
        fill,
        read,
        write
    } op_kind_t;

endpackage

`default_nettype wire

/* common/bank_stage_if.sv */
`default_nettype none

interface bank_stage_if import cache_pkg::*; ();

    logic       valid;
    op_kind_t   kind;
    line_addr_t addr;
    wsel_t      wsel;
    byteen_t    byteen;
    word_t      wdata;
    line_t      fill_data;
    core_tag_t  tag;
    logic       hit;

    // back-pressure from the data stage
    logic       stall;

    modport tag_side (
        output valid, kind, addr, wsel, byteen, wdata, fill_data, tag, hit,
        input  stall
    );

    modport data_side (
        input  valid, kind, addr, wsel, byteen, wdata, fill_data, tag, hit,
        output stall
    );

endinterface

`default_nettype wire

/* src/bank_fifo.sv */
`default_nettype none

module bank_fifo import cache_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t mem [fifo_depth];

    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0] count;
    logic                            push;
    logic                            pop;

    assign in_ready  = (count != fifo_depth);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* bank_pipe/bank_tag_stage.sv */
`default_nettype none

module bank_tag_stage import cache_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           core_req_valid,
    input  line_addr_t     core_req_addr,
    input  logic           core_req_rw,
    input  wsel_t          core_req_wsel,
    input  byteen_t        core_req_byteen,
    input  word_t          core_req_data,
    input  core_tag_t      core_req_tag,
    output logic           core_req_ready,
    input  logic           mem_rsp_valid,
    input  line_t          mem_rsp_data,
    output logic           mem_rsp_ready,
    bank_stage_if.tag_side stage
);

    logic [tag_bits-1:0]  tag_array [num_lines];
    logic [num_lines-1:0] valid_array;

    logic                 init_active;
    logic [set_bits-1:0]  init_ctr;

    // the single outstanding read miss
    logic                 miss_pending;
    line_addr_t           miss_addr;
    wsel_t                miss_wsel;
    core_tag_t            miss_tag;

    logic [set_bits-1:0]  req_set;
    logic [tag_bits-1:0]  req_tag;
    logic                 lookup_hit;
    logic                 advance;
    logic                 core_fire;
    logic                 fill_fire;
    logic                 fill_done;

    assign advance = !stage.stall;

    assign req_set    = core_req_addr[set_bits-1:0];
    assign req_tag    = core_req_addr[line_addr_bits-1:set_bits];
    assign lookup_hit = valid_array[req_set] && (tag_array[req_set] == req_tag);

    // core waits behind init and behind a pending miss
    assign core_req_ready = !init_active && !miss_pending && advance;
    assign mem_rsp_ready  = miss_pending && advance;

    assign core_fire = core_req_valid && core_req_ready;
    assign fill_fire = mem_rsp_valid && mem_rsp_ready;
    assign fill_done = stage.valid && (stage.kind == fill) && advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            init_active <= 1'b1;
            init_ctr    <= '0;
        end else if (init_active && advance) begin
            init_ctr <= init_ctr + 1'b1;
            if (init_ctr == set_bits'(num_lines - 1)) begin
                init_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            miss_pending <= 1'b0;
        end else if (core_fire && !core_req_rw && !lookup_hit) begin
            miss_pending <= 1'b1;
        end else if (fill_done) begin
            miss_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (core_fire && !core_req_rw) begin
            miss_addr <= core_req_addr;
            miss_wsel <= core_req_wsel;
            miss_tag  <= core_req_tag;
        end
    end

    // sweep clears valid bits, a fill installs the new tag
    always_ff @(posedge clk) begin
        if (init_active) begin
            valid_array[init_ctr] <= 1'b0;
        end else if (fill_fire) begin
            valid_array[miss_addr[set_bits-1:0]] <= 1'b1;
            tag_array[miss_addr[set_bits-1:0]]   <= miss_addr[line_addr_bits-1:set_bits];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage.valid <= 1'b0;
        end else if (advance) begin
            stage.valid <= init_active || fill_fire || core_fire;
        end
    end

    // priority is init, then fill, then core
    always_ff @(posedge clk) begin
        if (advance) begin
            stage.byteen    <= core_req_byteen;
            stage.wdata     <= core_req_data;
            stage.fill_data <= mem_rsp_data;
            if (init_active) begin
                stage.kind <= init;
                stage.addr <= line_addr_t'(init_ctr);
                stage.wsel <= '0;
                stage.tag  <= '0;
                stage.hit  <= 1'b0;
            end else if (fill_fire) begin
                stage.kind <= fill;
                stage.addr <= miss_addr;
                stage.wsel <= miss_wsel;
                stage.tag  <= miss_tag;
                stage.hit  <= 1'b0;
            end else begin
                stage.kind <= !core_fire ? none : (core_req_rw ? write : read);
                stage.addr <= core_req_addr;
                stage.wsel <= core_req_wsel;
                stage.tag  <= core_req_tag;
                stage.hit  <= lookup_hit;
            end
        end
    end

endmodule

`default_nettype wire

/* bank_pipe/bank_data_stage.sv */
`default_nettype none

module bank_data_stage import cache_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    bank_stage_if.data_side stage,
    output logic            rsp_valid,
    output core_rsp_t       rsp_data,
    output logic            mreq_valid,
    output mem_req_t        mreq_data,
    input  logic            rsp_ready,
    input  logic            mreq_ready
);

    line_t               data_array [num_lines];

    logic [set_bits-1:0] set_sel;
    logic                is_fill;
    logic                is_read;
    logic                is_write;
    logic                need_rsp;
    logic                need_mreq;
    logic                fire;
    word_t               rd_word;
    line_byteen_t        write_byteen;

    assign set_sel  = stage.addr[set_bits-1:0];
    assign is_fill  = stage.valid && (stage.kind == fill);
    assign is_read  = stage.valid && (stage.kind == read);
    assign is_write = stage.valid && (stage.kind == write);

    // each entry needs at most one of the two queues
    assign need_rsp  = is_fill || (is_read && stage.hit);
    assign need_mreq = (is_read && !stage.hit) || is_write;

    assign stage.stall = (need_rsp && !rsp_ready) || (need_mreq && !mreq_ready);
    assign fire        = !stage.stall;

    // fill returns its word straight from the incoming line
    assign rd_word = is_fill ? stage.fill_data[stage.wsel] : data_array[set_sel][stage.wsel];

    assign rsp_valid = need_rsp;
    assign rsp_data  = '{tag: stage.tag, data: rd_word};

    // word byte enables placed at the selected word of the line
    assign write_byteen = line_byteen_t'(stage.byteen) << (stage.wsel * word_bytes);

    assign mreq_valid = need_mreq;
    assign mreq_data  = '{
        rw:     is_write,
        addr:   stage.addr,
        byteen: is_write ? write_byteen : '1,
        data:   {line_words{stage.wdata}}
    };

    // no array update while reset is held
    always_ff @(posedge clk) begin
        if (!reset && fire) begin
            if (is_fill) begin
                data_array[set_sel] <= stage.fill_data;
            end else if (is_write && stage.hit) begin
                for (int b = 0; b < word_bytes; b++) begin
                    if (stage.byteen[b]) begin
                        data_array[set_sel][stage.wsel][b*8 +: 8] <= stage.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/cache_bank.sv */
`default_nettype none

module cache_bank import cache_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         core_req_valid,
    input  line_addr_t   core_req_addr,
    input  logic         core_req_rw,
    input  wsel_t        core_req_wsel,
    input  byteen_t      core_req_byteen,
    input  word_t        core_req_data,
    input  core_tag_t    core_req_tag,
    output logic         core_req_ready,
    output logic         core_rsp_valid,
    output word_t        core_rsp_data,
    output core_tag_t    core_rsp_tag,
    input  logic         core_rsp_ready,
    output logic         mem_req_valid,
    output logic         mem_req_rw,
    output line_addr_t   mem_req_addr,
    output line_byteen_t mem_req_byteen,
    output line_t        mem_req_data,
    input  logic         mem_req_ready,
    input  logic         mem_rsp_valid,
    input  line_t        mem_rsp_data,
    output logic         mem_rsp_ready
);

    logic      rsp_push_valid;
    logic      rsp_push_ready;
    core_rsp_t rsp_push_data;
    core_rsp_t rsp_head;
    logic      mreq_push_valid;
    logic      mreq_push_ready;
    mem_req_t  mreq_push_data;
    mem_req_t  mreq_head;

    bank_stage_if stage_bus ();

    bank_tag_stage tag_stage (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_addr   (core_req_addr),
        .core_req_rw     (core_req_rw),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready),
        .stage           (stage_bus.tag_side)
    );

    bank_data_stage data_stage (
        .clk        (clk),
        .reset      (reset),
        .stage      (stage_bus.data_side),
        .rsp_valid  (rsp_push_valid),
        .rsp_data   (rsp_push_data),
        .mreq_valid (mreq_push_valid),
        .mreq_data  (mreq_push_data),
        .rsp_ready  (rsp_push_ready),
        .mreq_ready (mreq_push_ready)
    );

    bank_fifo #(.payload_t(core_rsp_t)) rsp_queue (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rsp_push_valid),
        .in_data   (rsp_push_data),
        .in_ready  (rsp_push_ready),
        .out_valid (core_rsp_valid),
        .out_data  (rsp_head),
        .out_ready (core_rsp_ready)
    );

    bank_fifo #(.payload_t(mem_req_t)) mreq_queue (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mreq_push_valid),
        .in_data   (mreq_push_data),
        .in_ready  (mreq_push_ready),
        .out_valid (mem_req_valid),
        .out_data  (mreq_head),
        .out_ready (mem_req_ready)
    );

    assign core_rsp_data  = rsp_head.data;
    assign core_rsp_tag   = rsp_head.tag;
    assign mem_req_rw     = mreq_head.rw;
    assign mem_req_addr   = mreq_head.addr;
    assign mem_req_byteen = mreq_head.byteen;
    assign mem_req_data   = mreq_head.data;

endmodule

`default_nettype wire

/* dv/cache_bank_properties.sv */
`default_nettype none

module cache_bank_properties import cache_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         core_req_ready,
    input logic         core_rsp_valid,
    input logic         core_rsp_ready,
    input word_t        core_rsp_data,
    input core_tag_t    core_rsp_tag,
    input logic         mem_req_valid,
    input logic         mem_req_ready,
    input logic         mem_req_rw,
    input line_addr_t   mem_req_addr,
    input line_byteen_t mem_req_byteen,
    input line_t        mem_req_data,
    input logic         mem_rsp_valid,
    input logic         mem_rsp_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // response head held until the core takes it
    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=>
            core_rsp_valid && $stable(core_rsp_data) && $stable(core_rsp_tag))
        else $error("core response dropped or changed before it was accepted");

    mreq_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_rw) && $stable(mem_req_addr)
            && $stable(mem_req_byteen) && $stable(mem_req_data))
        else $error("memory request dropped or changed before it was accepted");

    // core blocked while a line read waits at the queue head
    read_blocks_core: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_rw |-> !core_req_ready)
        else $error("core request accepted while a memory read was queued");

    // miss stays open until the fill has passed the data stage
    fill_blocks_core: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && mem_rsp_ready |=> !core_req_ready)
        else $error("core request accepted right after a fill was taken");

endmodule

bind cache_bank cache_bank_properties props (
    .clk            (clk),
    .reset          (reset),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .core_rsp_data  (core_rsp_data),
    .core_rsp_tag   (core_rsp_tag),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_rw     (mem_req_rw),
    .mem_req_addr   (mem_req_addr),
    .mem_req_byteen (mem_req_byteen),
    .mem_req_data   (mem_req_data),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_ready  (mem_rsp_ready)
);

`default_nettype wire

/* dv/cache_bank_tb.sv */
`default_nettype none

module cache_bank_tb import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic         clk;
    logic         reset;
    logic         core_req_valid;
    line_addr_t   core_req_addr;
    logic         core_req_rw;
    wsel_t        core_req_wsel;
    byteen_t      core_req_byteen;
    word_t        core_req_data;
    core_tag_t    core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    core_tag_t    core_rsp_tag;
    logic         core_rsp_ready;
    logic         mem_req_valid;
    logic         mem_req_rw;
    line_addr_t   mem_req_addr;
    line_byteen_t mem_req_byteen;
    line_t        mem_req_data;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    line_t        mem_rsp_data;
    logic         mem_rsp_ready;

    // golden operations, one entry per line of the data file
    logic         op_rw[$];
    line_addr_t   op_addr[$];
    wsel_t        op_wsel[$];
    byteen_t      op_byteen[$];
    word_t        op_data[$];
    core_tag_t    op_tag[$];
    word_t        op_expect[$];
    int           num_ops;

    // expected traffic in order
    word_t        exp_rsp_data[$];
    core_tag_t    exp_rsp_tag[$];
    logic         exp_mem_rw[$];
    line_addr_t   exp_mem_addr[$];
    line_byteen_t exp_mem_byteen[$];
    word_t        exp_mem_word[$];

    // memory model, untouched lines keep their fill pattern
    line_t        mem_lines [line_addr_t];
    line_t        fill_line;
    int           fill_wait;
    logic         fill_taken;

    int           mismatches;
    int           other_errors;
    int           rsp_seen;
    int           mreq_seen;

    cache_bank DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic line_t model_line(input line_addr_t addr);
        line_t line;
        if (mem_lines.exists(addr)) begin
            line = mem_lines[addr];
        end else begin
            for (int w = 0; w < line_words; w++) begin
                line[w] = word_t'(addr) * 16 + word_t'(w);
            end
        end
        return line;
    endfunction

    function automatic void apply_mem_write(input line_addr_t addr, input line_byteen_t be,
                                            input line_t data);
        logic [line_words*word_bytes*8-1:0] flat;
        flat = model_line(addr);
        for (int b = 0; b < line_words * word_bytes; b++) begin
            if (be[b]) begin
                flat[b*8 +: 8] = data[b/word_bytes][(b%word_bytes)*8 +: 8];
            end
        end
        mem_lines[addr] = flat;
    endfunction

    // word byte enables moved to the chosen word of a line
    function automatic line_byteen_t line_enables(input wsel_t wsel, input byteen_t be);
        line_byteen_t en;
        en = '0;
        for (int b = 0; b < word_bytes; b++) begin
            en[int'(wsel) * word_bytes + b] = be[b];
        end
        return en;
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wsel;
        logic [31:0] f_be;
        logic [31:0] f_data;
        logic [31:0] f_tag;
        logic [31:0] f_exp;
        fd = $fopen("dv/cache_bank_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden stimulus file");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h",
                                f_op, f_addr, f_wsel, f_be, f_data, f_tag, f_exp);
                    if (n == 7) begin
                        op_rw.push_back(f_op[0]);
                        op_addr.push_back(line_addr_t'(f_addr));
                        op_wsel.push_back(wsel_t'(f_wsel));
                        op_byteen.push_back(byteen_t'(f_be));
                        op_data.push_back(f_data);
                        op_tag.push_back(core_tag_t'(f_tag));
                        op_expect.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
        num_ops = op_rw.size();
    endtask

    // direct-mapped tag model, write-through without write allocation
    task automatic build_expected();
        logic [num_lines-1:0] ref_valid;
        line_addr_t           ref_line [num_lines];
        logic [set_bits-1:0]  idx;
        ref_valid = '0;
        for (int i = 0; i < num_ops; i++) begin
            idx = op_addr[i][set_bits-1:0];
            if (op_rw[i]) begin
                exp_mem_rw.push_back(1'b1);
                exp_mem_addr.push_back(op_addr[i]);
                exp_mem_byteen.push_back(line_enables(op_wsel[i], op_byteen[i]));
                exp_mem_word.push_back(op_data[i]);
            end else begin
                if (!(ref_valid[idx] && ref_line[idx] == op_addr[i])) begin
                    exp_mem_rw.push_back(1'b0);
                    exp_mem_addr.push_back(op_addr[i]);
                    exp_mem_byteen.push_back('1);
                    exp_mem_word.push_back('0);
                    ref_valid[idx] = 1'b1;
                    ref_line[idx]  = op_addr[i];
                end
                exp_rsp_data.push_back(op_expect[i]);
                exp_rsp_tag.push_back(op_tag[i]);
            end
        end
    endtask

    task automatic check_rsp(input word_t data, input core_tag_t tag);
        word_t     exp_data;
        core_tag_t exp_tag;
        if (exp_rsp_data.size() == 0) begin
            $display("unexpected core response with tag %0h at %0t", tag, $time);
            other_errors++;
        end else begin
            exp_data = exp_rsp_data.pop_front();
            exp_tag  = exp_rsp_tag.pop_front();
            if (data !== exp_data || tag !== exp_tag) begin
                $display("Mismatch at %0t: response tag %0h data %08h, expected tag %0h data %08h",
                         $time, tag, data, exp_tag, exp_data);
                mismatches++;
            end
            rsp_seen++;
        end
    endtask

    task automatic check_mem_req(input logic rw, input line_addr_t addr,
                                 input line_byteen_t byteen, input line_t data);
        logic         exp_rw;
        line_addr_t   exp_addr;
        line_byteen_t exp_be;
        word_t        exp_word;
        logic         data_ok;
        int           lane;
        if (exp_mem_rw.size() == 0) begin
            $display("unexpected memory request to line %03h at %0t", addr, $time);
            other_errors++;
        end else begin
            exp_rw   = exp_mem_rw.pop_front();
            exp_addr = exp_mem_addr.pop_front();
            exp_be   = exp_mem_byteen.pop_front();
            exp_word = exp_mem_word.pop_front();
            // byte enables only matter for writes
            if (rw !== exp_rw || addr !== exp_addr || (exp_rw && byteen !== exp_be)) begin
                $display("Mismatch at %0t: memory rw %0b line %03h be %04h, expected %0b %03h %04h",
                         $time, rw, addr, byteen, exp_rw, exp_addr, exp_be);
                mismatches++;
            end
            // each enabled byte carries its byte lane of the core word
            data_ok = 1'b1;
            for (int b = 0; b < line_words * word_bytes; b++) begin
                if (exp_rw && exp_be[b]) begin
                    lane = b % word_bytes;
                    if (data[b/word_bytes][lane*8 +: 8] !== exp_word[lane*8 +: 8]) begin
                        data_ok = 1'b0;
                    end
                end
            end
            if (!data_ok) begin
                $display("Mismatch at %0t: memory write data %032h, expected word %08h",
                         $time, data, exp_word);
                mismatches++;
            end
            mreq_seen++;
        end
    endtask

    // core response side with random back-pressure
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                core_rsp_ready = ($urandom % 3) != 0;
                if (core_rsp_valid && core_rsp_ready) begin
                    check_rsp(core_rsp_data, core_rsp_tag);
                end
            end
        end
    end

    // memory side: pop requests, answer reads after a random delay
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (mem_rsp_valid && fill_taken) begin
                    mem_rsp_valid = 1'b0;
                end
                if (fill_wait > 0) begin
                    fill_wait--;
                    if (fill_wait == 0) begin
                        mem_rsp_valid = 1'b1;
                        mem_rsp_data  = fill_line;
                    end
                end
                fill_taken    = mem_rsp_valid && mem_rsp_ready;
                mem_req_ready = ($urandom % 4) != 0;
                if (mem_req_valid && mem_req_ready) begin
                    check_mem_req(mem_req_rw, mem_req_addr, mem_req_byteen, mem_req_data);
                    if (mem_req_rw) begin
                        apply_mem_write(mem_req_addr, mem_req_byteen, mem_req_data);
                    end else if (fill_wait > 0 || mem_rsp_valid) begin
                        $display("second memory read issued while a fill is outstanding");
                        other_errors++;
                    end else begin
                        fill_line = model_line(mem_req_addr);
                        fill_wait = 1 + int'($urandom % 6);
                    end
                end
            end
        end
    end

    initial begin
        @(posedge clk);
        repeat ((num_ops + 1) * 200) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", (num_ops + 1) * 200);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h74012b4d));
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_req_rw     = 1'b0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        fill_wait       = 0;
        fill_taken      = 1'b0;
        mismatches      = 0;
        other_errors    = 0;
        rsp_seen        = 0;
        mreq_seen       = 0;
        load_golden();
        build_expected();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < num_ops; i++) begin
            core_req_valid  = 1'b1;
            core_req_rw     = op_rw[i];
            core_req_addr   = op_addr[i];
            core_req_wsel   = op_wsel[i];
            core_req_byteen = op_byteen[i];
            core_req_data   = op_data[i];
            core_req_tag    = op_tag[i];
            while (!core_req_ready) @(negedge clk);
            // accepted on the rising edge in between
            @(negedge clk);
        end
        core_req_valid = 1'b0;
        while (exp_rsp_data.size() != 0 || exp_mem_rw.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        $display("%0d ops, %0d responses, %0d memory requests, %0d mismatches, %0d other errors",
                 num_ops, rsp_seen, mreq_seen, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && num_ops > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cache_bank_golden.txt */
# columns: op (0 read, 1 write) line_addr wsel byteen data tag expected_read_word
# all values in hex; expected word is 0 for writes
0 012 1 0 00000000 1 00000121
0 012 3 0 00000000 2 00000123
1 012 2 3 aabbccdd 3 00000000
0 012 2 0 00000000 4 0000ccdd
1 035 0 f 12345678 5 00000000
0 035 0 0 00000000 6 12345678
0 135 0 0 00000000 7 00001350
0 035 1 0 00000000 8 00000351
0 135 3 0 00000000 9 00001353
1 135 3 c deadbeef a 00000000
0 135 3 0 00000000 b dead1353
0 0ff 2 0 00000000 c 00000ff2
0 012 2 0 00000000 d 0000ccdd
0 035 0 0 00000000 e 12345678

/* project.f */
common/cache_pkg.sv
common/bank_stage_if.sv
src/bank_fifo.sv
bank_pipe/bank_tag_stage.sv
bank_pipe/bank_data_stage.sv
src/cache_bank.sv
dv/cache_bank_properties.sv
dv/cache_bank_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the cache bank testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_bank_tb -f project.f -Mdir obj_dir -o cache_bank_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/cache_bank_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log"; then
    exit 1
fi
exit 0
